//--- hw/video_pkg.sv
package video_pkg;

	localparam int CNT_W      = 11;                  // Raster counts and timing values
	localparam int COLOR_W    = 8;                   // One color channel
	localparam int FIFO_DEPTH = 64;                  // Pixel words, power of two
	localparam int FIFO_AW    = $clog2(FIFO_DEPTH);  // FIFO pointer width

	// Switch codes
	localparam logic [3:0] MODE_VGA    = 4'b0000;
	localparam logic [3:0] MODE_SVGA   = 4'b0001;
	localparam logic [3:0] MODE_HD720  = 4'b0010;  // Also the fallback
	localparam logic [3:0] MODE_XGA    = 4'b0011;
	localparam logic [3:0] MODE_SXGA   = 4'b1000;
	localparam logic [3:0] MODE_CAMERA = 4'b1001;

	////////////////////
	// Mode table
	// Live, front porch, sync, back porch
	////////////////////

	// 640x480
	localparam logic [CNT_W-1:0] H_LIVE_VGA = 11'd640;
	localparam logic [CNT_W-1:0] H_FP_VGA   = 11'd16;
	localparam logic [CNT_W-1:0] H_SW_VGA   = 11'd96;
	localparam logic [CNT_W-1:0] H_BP_VGA   = 11'd48;
	localparam logic [CNT_W-1:0] V_LIVE_VGA = 11'd480;
	localparam logic [CNT_W-1:0] V_FP_VGA   = 11'd11;
	localparam logic [CNT_W-1:0] V_SW_VGA   = 11'd2;
	localparam logic [CNT_W-1:0] V_BP_VGA   = 11'd31;
	localparam logic             POL_VGA    = 1'b1;  // Negative syncs

	// 800x600
	localparam logic [CNT_W-1:0] H_LIVE_SVGA = 11'd800;
	localparam logic [CNT_W-1:0] H_FP_SVGA   = 11'd40;
	localparam logic [CNT_W-1:0] H_SW_SVGA   = 11'd128;
	localparam logic [CNT_W-1:0] H_BP_SVGA   = 11'd88;
	localparam logic [CNT_W-1:0] V_LIVE_SVGA = 11'd600;
	localparam logic [CNT_W-1:0] V_FP_SVGA   = 11'd1;
	localparam logic [CNT_W-1:0] V_SW_SVGA   = 11'd4;
	localparam logic [CNT_W-1:0] V_BP_SVGA   = 11'd23;
	localparam logic             POL_SVGA    = 1'b0;

	// 1024x768
	localparam logic [CNT_W-1:0] H_LIVE_XGA = 11'd1024;
	localparam logic [CNT_W-1:0] H_FP_XGA   = 11'd24;
	localparam logic [CNT_W-1:0] H_SW_XGA   = 11'd136;
	localparam logic [CNT_W-1:0] H_BP_XGA   = 11'd160;
	localparam logic [CNT_W-1:0] V_LIVE_XGA = 11'd768;
	localparam logic [CNT_W-1:0] V_FP_XGA   = 11'd3;
	localparam logic [CNT_W-1:0] V_SW_XGA   = 11'd6;
	localparam logic [CNT_W-1:0] V_BP_XGA   = 11'd29;
	localparam logic             POL_XGA    = 1'b1;  // Negative syncs

	// 1280x720
	localparam logic [CNT_W-1:0] H_LIVE_HD720 = 11'd1280;
	localparam logic [CNT_W-1:0] H_FP_HD720   = 11'd110;
	localparam logic [CNT_W-1:0] H_SW_HD720   = 11'd40;
	localparam logic [CNT_W-1:0] H_BP_HD720   = 11'd220;
	localparam logic [CNT_W-1:0] V_LIVE_HD720 = 11'd720;
	localparam logic [CNT_W-1:0] V_FP_HD720   = 11'd5;
	localparam logic [CNT_W-1:0] V_SW_HD720   = 11'd5;
	localparam logic [CNT_W-1:0] V_BP_HD720   = 11'd20;
	localparam logic             POL_HD720    = 1'b0;

	// 1280x1024
	localparam logic [CNT_W-1:0] H_LIVE_SXGA = 11'd1280;
	localparam logic [CNT_W-1:0] H_FP_SXGA   = 11'd48;
	localparam logic [CNT_W-1:0] H_SW_SXGA   = 11'd112;
	localparam logic [CNT_W-1:0] H_BP_SXGA   = 11'd248;
	localparam logic [CNT_W-1:0] V_LIVE_SXGA = 11'd1024;
	localparam logic [CNT_W-1:0] V_FP_SXGA   = 11'd1;
	localparam logic [CNT_W-1:0] V_SW_SXGA   = 11'd3;
	localparam logic [CNT_W-1:0] V_BP_SXGA   = 11'd38;
	localparam logic             POL_SXGA    = 1'b0;

	// Camera, 720 lines with a narrower sync
	localparam logic [CNT_W-1:0] H_LIVE_CAMERA = 11'd1280;
	localparam logic [CNT_W-1:0] H_FP_CAMERA   = 11'd110;
	localparam logic [CNT_W-1:0] H_SW_CAMERA   = 11'd39;
	localparam logic [CNT_W-1:0] H_BP_CAMERA   = 11'd220;
	localparam logic [CNT_W-1:0] V_LIVE_CAMERA = 11'd720;
	localparam logic [CNT_W-1:0] V_FP_CAMERA   = 11'd4;
	localparam logic [CNT_W-1:0] V_SW_CAMERA   = 11'd4;
	localparam logic [CNT_W-1:0] V_BP_CAMERA   = 11'd22;
	localparam logic             POL_CAMERA    = 1'b0;

	////////////////////
	// Shared types
	////////////////////

	typedef struct packed {
		logic [COLOR_W-1:0] red;
		logic [COLOR_W-1:0] green;
		logic [COLOR_W-1:0] blue;
	} pixel_t;

	// End-of-interval counts, each one less than the running sum
	typedef struct packed {
		logic [CNT_W-1:0] h_sblnk;  // Last live pixel
		logic [CNT_W-1:0] h_ssync;
		logic [CNT_W-1:0] h_esync;
		logic [CNT_W-1:0] h_eblnk;  // Last pixel of the line
		logic [CNT_W-1:0] v_sblnk;
		logic [CNT_W-1:0] v_ssync;
		logic [CNT_W-1:0] v_esync;
		logic [CNT_W-1:0] v_eblnk;
		logic             polarity;  // 1 = negative sync
	} timing_cfg_t;

	typedef struct packed {
		logic hsync;
		logic vsync;
		logic de;
	} video_sync_t;

endpackage

//--- hw/video_mode_select.sv
`timescale 1ns/1ps

module video_mode_select
	import video_pkg::*;
(
	input  logic        clk50m_bufg,
	input  logic        RSTBTN,
	input  logic [3:0]  mode_sw,     // Raw switches
	output timing_cfg_t timing_cfg,
	output logic        restart      // One clock after a code change
);

	logic [3:0] sw_meta;  // First synchronizer stage
	logic [3:0] sw_sync;  // Second stage
	logic [3:0] code_q;   // Code in use
	logic [3:0] code_d;   // Code one clock back

	// Running sums of the four intervals minus one
	function automatic timing_cfg_t build_cfg(
		input logic [CNT_W-1:0] h_live,
		input logic [CNT_W-1:0] h_fp,
		input logic [CNT_W-1:0] h_sw,
		input logic [CNT_W-1:0] h_bp,
		input logic [CNT_W-1:0] v_live,
		input logic [CNT_W-1:0] v_fp,
		input logic [CNT_W-1:0] v_sw,
		input logic [CNT_W-1:0] v_bp,
		input logic             pol
	);
		timing_cfg_t cfg;
		cfg.h_sblnk  = h_live - 1'b1;
		cfg.h_ssync  = cfg.h_sblnk + h_fp;
		cfg.h_esync  = cfg.h_ssync + h_sw;
		cfg.h_eblnk  = cfg.h_esync + h_bp;
		cfg.v_sblnk  = v_live - 1'b1;
		cfg.v_ssync  = cfg.v_sblnk + v_fp;
		cfg.v_esync  = cfg.v_ssync + v_sw;
		cfg.v_eblnk  = cfg.v_esync + v_bp;
		cfg.polarity = pol;
		return cfg;
	endfunction

	// Two-flop synchronizer
	always_ff @(posedge clk50m_bufg) begin
		sw_meta <= mode_sw;
		sw_sync <= sw_meta;
	end

	// Code register and change detect
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			code_q  <= sw_sync;  // Track the switches so syncs idle correctly
			code_d  <= sw_sync;
			restart <= 1'b0;
		end else begin
			code_q  <= sw_sync;
			code_d  <= code_q;
			restart <= (code_q != code_d);  // Pulse one clock after the change
		end
	end

	////////////////////
	// Format lookup
	////////////////////
	always_comb begin
		case (code_q)
			MODE_VGA: timing_cfg = build_cfg(H_LIVE_VGA, H_FP_VGA, H_SW_VGA, H_BP_VGA,
				V_LIVE_VGA, V_FP_VGA, V_SW_VGA, V_BP_VGA, POL_VGA);
			MODE_SVGA: timing_cfg = build_cfg(H_LIVE_SVGA, H_FP_SVGA, H_SW_SVGA, H_BP_SVGA,
				V_LIVE_SVGA, V_FP_SVGA, V_SW_SVGA, V_BP_SVGA, POL_SVGA);
			MODE_XGA: timing_cfg = build_cfg(H_LIVE_XGA, H_FP_XGA, H_SW_XGA, H_BP_XGA,
				V_LIVE_XGA, V_FP_XGA, V_SW_XGA, V_BP_XGA, POL_XGA);
			MODE_SXGA: timing_cfg = build_cfg(H_LIVE_SXGA, H_FP_SXGA, H_SW_SXGA, H_BP_SXGA,
				V_LIVE_SXGA, V_FP_SXGA, V_SW_SXGA, V_BP_SXGA, POL_SXGA);
			MODE_CAMERA: timing_cfg = build_cfg(H_LIVE_CAMERA, H_FP_CAMERA, H_SW_CAMERA,
				H_BP_CAMERA, V_LIVE_CAMERA, V_FP_CAMERA, V_SW_CAMERA, V_BP_CAMERA, POL_CAMERA);
			MODE_HD720: timing_cfg = build_cfg(H_LIVE_HD720, H_FP_HD720, H_SW_HD720,
				H_BP_HD720, V_LIVE_HD720, V_FP_HD720, V_SW_HD720, V_BP_HD720, POL_HD720);
			default: timing_cfg = build_cfg(H_LIVE_HD720, H_FP_HD720, H_SW_HD720,
				H_BP_HD720, V_LIVE_HD720, V_FP_HD720, V_SW_HD720, V_BP_HD720, POL_HD720);
		endcase
	end

endmodule

//--- hw/pixel_ingress.sv
`timescale 1ns/1ps

module pixel_ingress
	import video_pkg::*;
(
	input  logic   clk50m_bufg,
	input  logic   RSTBTN,
	input  logic   pix_req,    // Source request, data stable while high
	input  pixel_t pix_data,
	output logic   pix_ack,
	input  logic   fifo_full,
	output logic   wr_en,      // One strobe per handshake
	output pixel_t wr_data
);

	// Four-phase slave
	typedef enum logic {
		ST_WAIT_REQ,   // Idle, ack low
		ST_WAIT_DROP   // Word taken, ack high until req falls
	} ingress_state_t;

	ingress_state_t state_q;

	// Write only from idle, and only with room
	assign wr_en   = (state_q == ST_WAIT_REQ) && pix_req && !fifo_full;
	assign wr_data = pix_data;  // Held stable by the source during req
	assign pix_ack = (state_q == ST_WAIT_DROP);

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			state_q <= ST_WAIT_REQ;
		end else begin
			case (state_q)
				ST_WAIT_REQ: begin
					if (wr_en)
						state_q <= ST_WAIT_DROP;  // Ack rises next clock
				end
				ST_WAIT_DROP: begin
					if (!pix_req)
						state_q <= ST_WAIT_REQ;   // Ack falls next clock
				end
				default: state_q <= ST_WAIT_REQ;
			endcase
		end
	end

	// Full FIFO simply stalls in ST_WAIT_REQ, word waits at the source

endmodule

//--- hw/pixel_fifo.sv
`timescale 1ns/1ps

module pixel_fifo
	import video_pkg::*;
(
	input  logic   clk50m_bufg,
	input  logic   RSTBTN,
	input  logic   wr_en,
	input  pixel_t wr_data,
	input  logic   rd_en,
	output pixel_t rd_data,  // Valid one clock after rd_en
	output logic   full,
	output logic   empty
);

	pixel_t             mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_AW:0]   count;   // One bit wider to hold FIFO_DEPTH
	logic               wr_ok;

	assign full  = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
	assign empty = (count == '0);
	assign wr_ok = wr_en && !full;   // Guard against overrun

	// Storage
	always_ff @(posedge clk50m_bufg) begin
		if (wr_ok)
			mem[wr_ptr] <= wr_data;
	end

	// Registered read port
	always_ff @(posedge clk50m_bufg) begin
		if (rd_en)
			rd_data <= mem[rd_ptr];
	end

	// Pointers and occupancy
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_ok)
				wr_ptr <= wr_ptr + 1'b1;  // Wraps at the power-of-two depth
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_ok, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // Both or neither
			endcase
		end
	end

endmodule

//--- hw/raster_scan.sv
`timescale 1ns/1ps

module raster_scan
	import video_pkg::*;
(
	input  logic        clk50m_bufg,
	input  logic        RSTBTN,
	input  timing_cfg_t timing_cfg,
	input  logic        restart,     // Back to the origin
	output logic        rd_en,
	input  pixel_t      rd_data,
	input  logic        fifo_empty,
	output video_sync_t video_sync,
	output pixel_t      video_rgb,
	output logic        underflow    // Sticky
);

	logic [CNT_W-1:0] hcnt;
	logic [CNT_W-1:0] vcnt;
	logic             h_end;      // Last pixel of the line
	logic             v_end;      // Last line of the frame
	logic             active;
	logic             hsync_raw;  // Before polarity
	logic             vsync_raw;
	logic             took_q;     // A word was read for the pixel on the output

	////////////////////
	// Decode
	////////////////////
	assign h_end  = (hcnt >= timing_cfg.h_eblnk);  // >= in case the mode just shrank
	assign v_end  = (vcnt >= timing_cfg.v_eblnk);
	assign active = (hcnt <= timing_cfg.h_sblnk) && (vcnt <= timing_cfg.v_sblnk);

	// Past sync start, up to sync end
	assign hsync_raw = (hcnt > timing_cfg.h_ssync) && (hcnt <= timing_cfg.h_esync);
	assign vsync_raw = (vcnt > timing_cfg.v_ssync) && (vcnt <= timing_cfg.v_esync);

	// One word per live pixel, the only place empty is checked
	assign rd_en = active && !fifo_empty;

	////////////////////
	// Counters
	////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN || restart) begin
			hcnt <= '0;
			vcnt <= '0;
		end else if (h_end) begin
			hcnt <= '0;
			if (v_end)
				vcnt <= '0;            // Frame wrap
			else
				vcnt <= vcnt + 1'b1;   // Next line
		end else begin
			hcnt <= hcnt + 1'b1;       // One pixel per clock
		end
	end

	////////////////////
	// Output register
	////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			video_sync.hsync <= timing_cfg.polarity;  // Inactive level
			video_sync.vsync <= timing_cfg.polarity;
			video_sync.de    <= 1'b0;
			took_q           <= 1'b0;
			underflow        <= 1'b0;
		end else begin
			video_sync.hsync <= hsync_raw ^ timing_cfg.polarity;
			video_sync.vsync <= vsync_raw ^ timing_cfg.polarity;
			video_sync.de    <= active;
			took_q           <= rd_en;
			if (restart)
				underflow <= 1'b0;
			else if (active && fifo_empty)
				underflow <= 1'b1;  // Live pixel with nothing to show
		end
	end

	// FIFO read port is the pixel register, black when nothing was read
	assign video_rgb = took_q ? rd_data : '0;

endmodule

//--- hw/video_out_top.sv
`timescale 1ns/1ps

module video_out_top
	import video_pkg::*;
(
	input  logic        clk50m_bufg,
	input  logic        RSTBTN,
	input  logic [3:0]  mode_sw,
	input  logic        pix_req,
	input  pixel_t      pix_data,
	output logic        pix_ack,
	output video_sync_t video_sync,
	output pixel_t      video_rgb,
	output logic        underflow
);

	timing_cfg_t timing_cfg;
	logic        restart;
	logic        wr_en;
	pixel_t      wr_data;
	logic        fifo_full;
	logic        rd_en;
	pixel_t      rd_data;
	logic        fifo_empty;

	// Switches to timing
	video_mode_select u_mode_select (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.mode_sw     (mode_sw),
		.timing_cfg  (timing_cfg),
		.restart     (restart)
	);

	// Handshake to FIFO writes
	pixel_ingress u_ingress (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.pix_req     (pix_req),
		.pix_data    (pix_data),
		.pix_ack     (pix_ack),
		.fifo_full   (fifo_full),
		.wr_en       (wr_en),
		.wr_data     (wr_data)
	);

	pixel_fifo u_fifo (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.wr_en       (wr_en),
		.wr_data     (wr_data),
		.rd_en       (rd_en),
		.rd_data     (rd_data),
		.full        (fifo_full),
		.empty       (fifo_empty)
	);

	// Raster and pixel output
	raster_scan u_raster (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.timing_cfg  (timing_cfg),
		.restart     (restart),
		.rd_en       (rd_en),
		.rd_data     (rd_data),
		.fifo_empty  (fifo_empty),
		.video_sync  (video_sync),
		.video_rgb   (video_rgb),
		.underflow   (underflow)
	);

endmodule

//--- dv/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk50m_bufg,
	output logic RSTBTN
);

	localparam time HALF_PERIOD = 10ns;  // 50 MHz

	initial begin
		clk50m_bufg = 1'b0;
		forever #(HALF_PERIOD) clk50m_bufg = ~clk50m_bufg;
	end

	// Reset held over three rising edges, released just after the third
	initial begin
		RSTBTN = 1'b1;
		repeat (3) @(posedge clk50m_bufg);
		#1 RSTBTN = 1'b0;
	end

endmodule

//--- dv/video_out_checker.sv
`timescale 1ns/1ps

module video_out_checker
	import video_pkg::*;
(
	input logic        clk50m_bufg,
	input logic        RSTBTN,
	input logic        pix_ack,
	input video_sync_t video_sync,
	input pixel_t      video_rgb,
	input logic        underflow
);

	int     value_errors = 0;   // Wrong values
	int     other_fails  = 0;   // Timeouts, file trouble, lost words
	logic   pix_check_en = 1'b0;
	logic   de_seen      = 1'b0;  // de high since arming
	logic   black_seen   = 1'b0;  // Underflow pixel shown
	pixel_t exp_q[$];             // Pixels accepted in order

	task automatic value_fail(input string msg);
		$display("FAILED at %0t: %s", $time, msg);
		value_errors++;
	endtask

	task automatic plain_fail(input string msg);
		$display("Failure at %0t: %s", $time, msg);
		other_fails++;
	endtask

	// Four-state compare so an unknown output never passes
	task automatic expect_int(input string what, input logic [31:0] got, input int exp);
		if (got !== exp)
			value_fail($sformatf("%s is %0d, expected %0d", what, got, exp));
	endtask

	////////////////////
	// Reset state
	////////////////////
	task automatic check_reset_outputs();
		expect_int("pix_ack after reset", pix_ack, 0);
		expect_int("de after reset", video_sync.de, 0);
		expect_int("underflow after reset", underflow, 0);
		expect_int("rgb after reset", video_rgb, 0);
	endtask

	task automatic check_idle_syncs(input logic pol);
		expect_int("idle hsync", video_sync.hsync, pol);  // Inactive = polarity flag
		expect_int("idle vsync", video_sync.vsync, pol);
	endtask

	// Leading edge of hsync (use_v = 0) or vsync (use_v = 1)
	task automatic wait_sync_lead(input bit use_v, input logic act, input int limit,
		output bit ok);
		logic prev;
		logic cur;
		int   n;
		ok = 1'b0;
		prev = use_v ? video_sync.vsync : video_sync.hsync;
		for (n = 0; n < limit && !ok; n++) begin
			@(posedge clk50m_bufg);
			cur = use_v ? video_sync.vsync : video_sync.hsync;
			if (cur == act && prev != act)
				ok = 1'b1;
			prev = cur;
		end
		if (!ok)
			plain_fail($sformatf("timed out waiting for a %s edge", use_v ? "vsync" : "hsync"));
	endtask

	////////////////////
	// Line timing over three lines
	////////////////////
	task automatic measure_lines(input int h_total, input int h_live, input int h_sw,
		input logic pol);
		logic act;
		logic prev;
		logic cur;
		int   period;
		int   width;
		int   de_run;
		int   line;
		bit   ok;
		bit   edge_hit;
		act = ~pol;
		wait_sync_lead(1'b0, act, 4000, ok);
		if (!ok)
			return;
		for (line = 0; line < 3; line++) begin
			period   = 1;  // Leading sample itself
			width    = 1;
			de_run   = video_sync.de;
			edge_hit = 1'b0;
			prev     = act;
			while (!edge_hit && period <= 4000) begin
				@(posedge clk50m_bufg);
				cur = video_sync.hsync;
				if (cur == act && prev != act) begin
					edge_hit = 1'b1;
				end else begin
					period++;
					if (cur == act)
						width++;
					if (video_sync.de)
						de_run++;
				end
				prev = cur;
			end
			if (!edge_hit) begin
				plain_fail("timed out waiting for the next hsync edge");
				return;
			end
			expect_int("hsync period", period, h_total);
			expect_int("hsync width", width, h_sw);  // Wrong polarity shows here too
			expect_int("de run per line", de_run, h_live);
		end
	endtask

	////////////////////
	// Frame timing
	////////////////////
	task automatic measure_frame(input int v_total, input int v_live, input logic pol);
		logic act;
		logic prev_h;
		logic prev_v;
		logic prev_de;
		int   lines;
		int   de_lines;
		int   n;
		bit   ok;
		bit   edge_hit;
		act = ~pol;
		wait_sync_lead(1'b1, act, 1000000, ok);
		if (!ok)
			return;
		lines    = 0;
		de_lines = 0;
		edge_hit = 1'b0;
		prev_h   = video_sync.hsync;
		prev_v   = video_sync.vsync;
		prev_de  = video_sync.de;
		for (n = 0; n < 1000000 && !edge_hit; n++) begin
			@(posedge clk50m_bufg);
			if (video_sync.hsync == act && prev_h != act)
				lines++;
			if (video_sync.de && !prev_de)
				de_lines++;  // One rise per live line
			if (video_sync.vsync == act && prev_v != act)
				edge_hit = 1'b1;
			prev_h  = video_sync.hsync;
			prev_v  = video_sync.vsync;
			prev_de = video_sync.de;
		end
		if (!edge_hit) begin
			plain_fail("timed out waiting for the end of the frame");
			return;
		end
		expect_int("vsync period in lines", lines, v_total);
		expect_int("lines with de", de_lines, v_live);
	endtask

	////////////////////
	// Pixel order
	////////////////////
	task automatic arm_pixels();
		exp_q.delete();
		de_seen      = 1'b0;
		black_seen   = 1'b0;
		pix_check_en = 1'b1;
	endtask

	// Words past the FIFO depth may only be acked once reads have begun
	task automatic expect_pixel(input pixel_t p, input bit over_full);
		if (over_full && !de_seen)
			value_fail("pix_ack rose on a full FIFO before any read");
		exp_q.push_back(p);
	endtask

	task automatic stop_pixels();
		pix_check_en = 1'b0;
		if (exp_q.size() != 0)
			plain_fail($sformatf("%0d accepted pixels were never shown", exp_q.size()));
	endtask

	always @(posedge clk50m_bufg) begin
		if (pix_check_en && !RSTBTN && video_sync.de) begin
			de_seen = 1'b1;
			if (exp_q.size() > 0) begin
				if (video_rgb !== exp_q[0])
					value_fail($sformatf("pixel %06h, expected %06h", video_rgb, exp_q[0]));
				void'(exp_q.pop_front());
			end else begin
				// FIFO ran dry
				if (video_rgb !== '0)
					value_fail($sformatf("pixel %06h on underflow, expected black", video_rgb));
				if (underflow !== 1'b1)
					value_fail("underflow low while showing black");
				black_seen = 1'b1;
			end
		end
	end

	task automatic report();
		$display("Error counts: %0d wrong values, %0d other failures",
			value_errors, other_fails);
	endtask

endmodule

//--- dv/video_out_tb.sv
`timescale 1ns/1ps

module video_out_tb
	import video_pkg::*;
();

	localparam int MAX_CASES = 16;
	localparam int ACK_LIMIT = 100000;  // Cycles per handshake phase

	logic        clk50m_bufg;
	logic        RSTBTN;
	logic [3:0]  mode_sw;
	logic        pix_req;
	pixel_t      pix_data;
	logic        pix_ack;
	video_sync_t video_sync;
	pixel_t      video_rgb;
	logic        underflow;

	// One entry per pattern line
	logic [3:0]  case_mode  [MAX_CASES];
	int          case_npix  [MAX_CASES];
	int          case_htot  [MAX_CASES];
	int          case_hlive [MAX_CASES];
	int          case_hsw   [MAX_CASES];
	int          case_vtot  [MAX_CASES];
	int          case_vlive [MAX_CASES];
	logic        case_pol   [MAX_CASES];
	bit          case_frame [MAX_CASES];
	int          n_cases;

	tb_clk_gen u_clk (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN)
	);

	video_out_top u_dut (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.mode_sw     (mode_sw),
		.pix_req     (pix_req),
		.pix_data    (pix_data),
		.pix_ack     (pix_ack),
		.video_sync  (video_sync),
		.video_rgb   (video_rgb),
		.underflow   (underflow)
	);

	video_out_checker u_chk (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.pix_ack     (pix_ack),
		.video_sync  (video_sync),
		.video_rgb   (video_rgb),
		.underflow   (underflow)
	);

	task automatic read_patterns();
		int    fd;
		int    rc;
		int    m, npix, ht, hl, hs, vt, vl, pol, fr;
		string line;
		n_cases = 0;
		fd = $fopen("dv/video_patterns.txt", "r");
		if (fd == 0) begin
			u_chk.plain_fail("cannot open dv/video_patterns.txt");
			return;
		end
		while (!$feof(fd) && n_cases < MAX_CASES) begin
			rc = $fgets(line, fd);
			if (rc > 0 && line.getc(0) != "#") begin  // Skip the column notes
				rc = $sscanf(line, "%b %d %d %d %d %d %d %d %d",
					m, npix, ht, hl, hs, vt, vl, pol, fr);
				if (rc == 9) begin
					case_mode[n_cases]  = m[3:0];
					case_npix[n_cases]  = npix;
					case_htot[n_cases]  = ht;
					case_hlive[n_cases] = hl;
					case_hsw[n_cases]   = hs;
					case_vtot[n_cases]  = vt;
					case_vlive[n_cases] = vl;
					case_pol[n_cases]   = pol[0];
					case_frame[n_cases] = fr[0];
					n_cases++;
				end
			end
		end
		$fclose(fd);
		if (n_cases == 0)
			u_chk.plain_fail("no test cases found in the pattern file");
	endtask

	////////////////////
	// Four-phase source
	////////////////////
	task automatic push_pixel(input pixel_t p, input bit over_full);
		int n;
		bit got;
		@(posedge clk50m_bufg);
		#1;
		pix_data = p;
		pix_req  = 1'b1;
		got = 1'b0;
		for (n = 0; n < ACK_LIMIT && !got; n++) begin
			@(posedge clk50m_bufg);
			#1;
			got = pix_ack;
		end
		if (!got) begin
			u_chk.plain_fail("timed out waiting for pix_ack to rise");
			pix_req = 1'b0;
			return;
		end
		u_chk.expect_pixel(p, over_full);
		pix_req = 1'b0;
		got = 1'b0;
		for (n = 0; n < ACK_LIMIT && !got; n++) begin
			@(posedge clk50m_bufg);
			#1;
			got = !pix_ack;
		end
		if (!got)
			u_chk.plain_fail("timed out waiting for pix_ack to fall");
	endtask

	// Fill during vertical blanking and watch the drain and the underflow
	task automatic run_pixel_test(input int npix, input logic pol);
		int     i;
		int     n;
		bit     ok;
		pixel_t p;
		u_chk.wait_sync_lead(1'b1, ~pol, 1500000, ok);
		if (!ok)
			return;
		u_chk.arm_pixels();
		for (i = 0; i < npix; i++) begin
			p = 24'($urandom);
			push_pixel(p, i >= FIFO_DEPTH);
		end
		ok = 1'b0;
		for (n = 0; n < 100000 && !ok; n++) begin
			@(posedge clk50m_bufg);
			ok = u_chk.black_seen;
		end
		if (!ok)
			u_chk.plain_fail("timed out waiting for black pixels after the pushed words");
		u_chk.stop_pixels();
	endtask

	initial begin
		int seed;
		int i;
		int n;
		seed     = $urandom(50);
		pix_req  = 1'b0;
		pix_data = '0;
		mode_sw  = MODE_HD720;
		read_patterns();
		if (n_cases > 0)
			mode_sw = case_mode[0];

		for (n = 0; n < 1000 && RSTBTN !== 1'b0; n++)
			#1;
		if (RSTBTN !== 1'b0)
			u_chk.plain_fail("reset never released");
		#1;
		if (n_cases > 0) begin
			u_chk.check_reset_outputs();
			@(posedge clk50m_bufg);  // First edge out of reset
			#1;
			u_chk.check_idle_syncs(case_pol[0]);
		end

		for (i = 0; i < n_cases; i++) begin
			@(posedge clk50m_bufg);
			#1;
			mode_sw = case_mode[i];
			repeat (8) @(posedge clk50m_bufg);  // Synchronizer, code, restart, output
			u_chk.measure_lines(case_htot[i], case_hlive[i], case_hsw[i], case_pol[i]);
			if (case_frame[i])
				u_chk.measure_frame(case_vtot[i], case_vlive[i], case_pol[i]);
			if (case_npix[i] > 0)
				run_pixel_test(case_npix[i], case_pol[i]);
		end

		u_chk.report();
		if (u_chk.value_errors == 0 && u_chk.other_fails == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- dv/video_patterns.txt
# mode(binary) npix h_total h_live h_sync v_total v_live polarity frame
# polarity 1 = negative sync, frame 1 = count a whole frame, npix > 0 runs the pixel test
0000 68 800 640 96 524 480 1 1
0001 0 1056 800 128 628 600 0 1
0010 0 1650 1280 40 750 720 0 0
0011 0 1344 1024 136 806 768 1 0
1000 0 1688 1280 112 1066 1024 0 0
1001 0 1649 1280 39 750 720 0 0
0111 0 1650 1280 40 750 720 0 0

//--- video_out_top.f
hw/video_pkg.sv
hw/video_mode_select.sv
hw/pixel_ingress.sv
hw/pixel_fifo.sv
hw/raster_scan.sv
hw/video_out_top.sv
dv/tb_clk_gen.sv
dv/video_out_checker.sv
dv/video_out_tb.sv
